// ==== conv1x1_layer.f ====
+incdir+src
src/cnn_pkg.sv
src/replay_buffer.sv
src/weight_bank.sv
src/channel_mac.sv
src/relu_requant.sv
src/conv1x1_layer.sv
tests/tb_clock.sv
tests/conv1x1_layer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the conv1x1_layer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module conv1x1_layer_tb \
	-f conv1x1_layer.f \
	-o sim_conv1x1

./obj_dir/sim_conv1x1 > sim.log 2>&1 || true
cat sim.log

if grep -q 'All tests passed!' sim.log; then
	echo "Simulation PASSED"
	exit 0
else
	echo "Simulation FAILED"
	exit 1
fi

// ==== src/channel_mac.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cnn_defs.svh"

module channel_mac (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     tap_valid,
	input  cnn_pkg::tap_t            tap,
	output logic [`OUT_CH_W-1:0]     rd_out_ch,
	output logic [`IN_CH_W-1:0]      rd_in_ch,
	input  logic signed [`WGT_W-1:0] rd_weight,
	output logic                     acc_valid,
	output cnn_pkg::acc_t            acc
);

	logic signed [`ACC_W-1:0] pix_ext;
	logic signed [`ACC_W-1:0] wgt_ext;
	logic signed [`ACC_W-1:0] product;
	logic signed [`ACC_W-1:0] sum_base;
	logic signed [`ACC_W-1:0] sum_next;
	logic signed [`ACC_W-1:0] sum_q;

	// Weight lookup follows the tap tags directly
	assign rd_out_ch = tap.out_ch;
	assign rd_in_ch  = tap.in_ch;

	////////////////////////////////////////////////////////////
	// Multiply

	// Pixel is unsigned, weight is signed
	assign pix_ext = {{(`ACC_W - `PIX_W){1'b0}}, tap.value};
	assign wgt_ext = {{(`ACC_W - `WGT_W){rd_weight[`WGT_W-1]}}, rd_weight};
	assign product = pix_ext * wgt_ext;

	////////////////////////////////////////////////////////////
	// Accumulate over input channels

	// Channel 0 starts a new pixel
	assign sum_base = (tap.in_ch == '0) ? '0 : sum_q;
	assign sum_next = sum_base + product;

	always_ff @(posedge clk) begin
		if (tap_valid) begin
			sum_q <= sum_next;
		end
	end

	// Finished sum leaves while the next pixel starts summing
	always_ff @(posedge clk) begin
		if (tap_valid && tap.last_in_ch) begin
			acc.sum    <= sum_next;
			acc.out_ch <= tap.out_ch;
			acc.pixel  <= tap.pixel;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			acc_valid <= 1'b0;
		end else begin
			acc_valid <= tap_valid && tap.last_in_ch;
		end
	end

endmodule

`default_nettype wire

// ==== src/cnn_defs.svh ====
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

////////////////////////////////////////////////////////////
// Feature map geometry
`define IMG_W       4
`define NUM_PIX     (`IMG_W * `IMG_W)
`define CH_IN       4
`define CH_OUT      3
`define MAP_WORDS   (`CH_IN * `IMG_W * `IMG_W)

////////////////////////////////////////////////////////////
// Data widths
`define PIX_W       8
`define WGT_W       8
`define ACC_W       20

// Index widths for the tags and counters
`define IN_CH_W     2
`define OUT_CH_W    2
`define PIX_IDX_W   4
`define ADDR_W      6

// Idle cycles between passes, and the requantize shift
`define GAP_CYCLES  (`IMG_W + 1)
`define GAP_W       3
`define REQ_SHIFT   4

`endif

// ==== src/cnn_pkg.sv ====
`default_nettype none

`include "cnn_defs.svh"

package cnn_pkg;

	// Stored word on its way into the MAC
	typedef struct packed {
		logic [`PIX_W-1:0]     value;
		logic [`IN_CH_W-1:0]   in_ch;
		logic [`OUT_CH_W-1:0]  out_ch;
		logic [`PIX_IDX_W-1:0] pixel;
		logic                  last_in_ch;
	} tap_t;

	// Finished sum over the input channels of one pixel
	typedef struct packed {
		logic signed [`ACC_W-1:0] sum;
		logic [`OUT_CH_W-1:0]     out_ch;
		logic [`PIX_IDX_W-1:0]    pixel;
	} acc_t;

	// Result pixel after ReLU and clipping
	typedef struct packed {
		logic [`PIX_W-1:0]     value;
		logic [`OUT_CH_W-1:0]  out_ch;
		logic [`PIX_IDX_W-1:0] pixel;
	} out_t;

	// Host weight write
	typedef struct packed {
		logic [`OUT_CH_W-1:0]     out_ch;
		logic [`IN_CH_W-1:0]      in_ch;
		logic signed [`WGT_W-1:0] weight;
	} wgt_wr_t;

endpackage

`default_nettype wire

// ==== src/conv1x1_layer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cnn_defs.svh"

module conv1x1_layer (
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_in,
	input  logic [`PIX_W-1:0] pxl_in,
	input  logic              wgt_we,
	input  cnn_pkg::wgt_wr_t  wgt,
	output logic              out_valid,
	output cnn_pkg::out_t     out,
	output logic              idle,
	output logic              frame_done
);

	logic                     tap_valid;
	cnn_pkg::tap_t            tap;
	logic [`OUT_CH_W-1:0]     rd_out_ch;
	logic [`IN_CH_W-1:0]      rd_in_ch;
	logic signed [`WGT_W-1:0] rd_weight;
	logic                     acc_valid;
	cnn_pkg::acc_t            acc;

	////////////////////////////////////////////////////////////
	// Store and replay the input map
	replay_buffer u_replay_buffer (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.pxl_in     (pxl_in),
		.tap_valid  (tap_valid),
		.tap        (tap),
		.idle       (idle),
		.frame_done (frame_done)
	);

	weight_bank u_weight_bank (
		.clk       (clk),
		.reset     (reset),
		.wgt_we    (wgt_we),
		.wgt       (wgt),
		.rd_out_ch (rd_out_ch),
		.rd_in_ch  (rd_in_ch),
		.rd_weight (rd_weight)
	);

	////////////////////////////////////////////////////////////
	// Sum over input channels, then ReLU and requantize
	channel_mac u_channel_mac (
		.clk       (clk),
		.reset     (reset),
		.tap_valid (tap_valid),
		.tap       (tap),
		.rd_out_ch (rd_out_ch),
		.rd_in_ch  (rd_in_ch),
		.rd_weight (rd_weight),
		.acc_valid (acc_valid),
		.acc       (acc)
	);

	relu_requant u_relu_requant (
		.clk       (clk),
		.reset     (reset),
		.acc_valid (acc_valid),
		.acc       (acc),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

`default_nettype wire

// ==== src/relu_requant.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cnn_defs.svh"

module relu_requant (
	input  logic          clk,
	input  logic          reset,
	input  logic          acc_valid,
	input  cnn_pkg::acc_t acc,
	output logic          out_valid,
	output cnn_pkg::out_t out
);

	localparam int PIX_MAX = (1 << `PIX_W) - 1;

	logic signed [`ACC_W-1:0] shifted;
	logic [`PIX_W-1:0]        clipped;

	assign shifted = $signed(acc.sum) >>> `REQ_SHIFT;

	// ReLU, then saturate at the top of the pixel range
	always_comb begin
		if (shifted[`ACC_W-1]) begin
			clipped = '0;
		end else if (shifted > `ACC_W'(PIX_MAX)) begin
			clipped = `PIX_W'(PIX_MAX);
		end else begin
			clipped = shifted[`PIX_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (acc_valid) begin
			out.value  <= clipped;
			out.out_ch <= acc.out_ch;
			out.pixel  <= acc.pixel;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= acc_valid;
		end
	end

endmodule

`default_nettype wire

// ==== src/replay_buffer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cnn_defs.svh"

module replay_buffer (
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_in,
	input  logic [`PIX_W-1:0] pxl_in,
	output logic              tap_valid,
	output cnn_pkg::tap_t     tap,
	output logic              idle,
	output logic              frame_done
);

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_FILL,
		PH_GAP,
		PH_READ,
		PH_DRAIN
	} phase_t;

	phase_t                phase;
	logic [`ADDR_W-1:0]    addr;
	logic [`IN_CH_W-1:0]   in_ch_cnt;
	logic [`PIX_IDX_W-1:0] pix_cnt;
	logic [`OUT_CH_W-1:0]  pass_cnt;
	logic [`GAP_W-1:0]     gap_cnt;
	logic [`PIX_W-1:0]     mem [0:`MAP_WORDS-1];
	logic                  accept;
	logic                  step;
	logic                  last_word;
	logic                  last_in_ch;

	// Input words only count while idle or still filling
	assign accept     = valid_in && (phase == PH_IDLE || phase == PH_FILL);
	assign step       = accept || (phase == PH_READ);
	assign last_word  = (addr == `ADDR_W'(`MAP_WORDS - 1));
	assign last_in_ch = (in_ch_cnt == `IN_CH_W'(`CH_IN - 1));
	assign idle       = (phase == PH_IDLE);

	////////////////////////////////////////////////////////////
	// Word, channel and pixel counters
	always_ff @(posedge clk) begin
		if (reset) begin
			addr      <= '0;
			in_ch_cnt <= '0;
			pix_cnt   <= '0;
		end else if (step) begin
			if (last_word) begin
				addr      <= '0;
				in_ch_cnt <= '0;
				pix_cnt   <= '0;
			end else begin
				addr <= addr + 1'b1;
				if (last_in_ch) begin
					in_ch_cnt <= '0;
					pix_cnt   <= pix_cnt + 1'b1;
				end else begin
					in_ch_cnt <= in_ch_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Pass sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			phase      <= PH_IDLE;
			pass_cnt   <= '0;
			gap_cnt    <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= (phase == PH_DRAIN);
			case (phase)
				PH_IDLE, PH_FILL: begin
					if (accept) begin
						phase <= last_word ? PH_GAP : PH_FILL;
						if (last_word) begin
							pass_cnt <= pass_cnt + 1'b1;
							gap_cnt  <= '0;
						end
					end
				end
				PH_GAP: begin
					if (gap_cnt == `GAP_W'(`GAP_CYCLES - 1)) begin
						phase   <= PH_READ;
						gap_cnt <= '0;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				PH_READ: begin
					if (last_word) begin
						// Final pass goes to drain, others wait out a gap
						if (pass_cnt == `OUT_CH_W'(`CH_OUT - 1)) begin
							phase <= PH_DRAIN;
						end else begin
							phase    <= PH_GAP;
							pass_cnt <= pass_cnt + 1'b1;
						end
					end
				end
				default: begin
					phase    <= PH_IDLE;
					pass_cnt <= '0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Map memory and tap register
	always_ff @(posedge clk) begin
		if (accept) begin
			mem[addr] <= pxl_in;
		end
	end

	always_ff @(posedge clk) begin
		if (step) begin
			tap.value      <= (phase == PH_READ) ? mem[addr] : pxl_in;
			tap.in_ch      <= in_ch_cnt;
			tap.out_ch     <= pass_cnt;
			tap.pixel      <= pix_cnt;
			tap.last_in_ch <= last_in_ch;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tap_valid <= 1'b0;
		end else begin
			tap_valid <= step;
		end
	end

endmodule

`default_nettype wire

// ==== src/weight_bank.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cnn_defs.svh"

module weight_bank (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     wgt_we,
	input  cnn_pkg::wgt_wr_t         wgt,
	input  logic [`OUT_CH_W-1:0]     rd_out_ch,
	input  logic [`IN_CH_W-1:0]      rd_in_ch,
	output logic signed [`WGT_W-1:0] rd_weight
);

	logic signed [`WGT_W-1:0] bank [0:`CH_OUT-1][0:`CH_IN-1];
	logic                     wr_in_range;

	// Writes to a missing output channel are dropped
	assign wr_in_range = (wgt.out_ch < `OUT_CH_W'(`CH_OUT));

	////////////////////////////////////////////////////////////
	// Host write port
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int oc = 0; oc < `CH_OUT; oc++) begin
				for (int ic = 0; ic < `CH_IN; ic++) begin
					bank[oc][ic] <= '0;
				end
			end
		end else if (wgt_we && wr_in_range) begin
			bank[wgt.out_ch][wgt.in_ch] <= wgt.weight;
		end
	end

	////////////////////////////////////////////////////////////
	// Asynchronous read for the MAC
	always_comb begin
		rd_weight = '0;
		if (rd_out_ch < `OUT_CH_W'(`CH_OUT)) begin
			rd_weight = bank[rd_out_ch][rd_in_ch];
		end
	end

endmodule

`default_nettype wire

// ==== tests/conv1x1_layer_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cnn_defs.svh"

module conv1x1_layer_tb;

	localparam int CLK_PERIOD   = 4;
	localparam int NUM_OUT      = `CH_OUT * `NUM_PIX;
	localparam int PASS_CYCLES  = `GAP_CYCLES + `MAP_WORDS;
	// Worst case fill with gaps, the replay passes and some slack
	localparam int FRAME_CYCLES = 4 * `MAP_WORDS + (`CH_OUT - 1) * PASS_CYCLES + 32;
	localparam int WATCHDOG_CYCLES = 6 * FRAME_CYCLES + 8 + 200;

	logic              clk;
	logic              reset;
	logic              valid_in;
	logic [`PIX_W-1:0] pxl_in;
	logic              wgt_we;
	cnn_pkg::wgt_wr_t  wgt;
	logic              out_valid;
	cnn_pkg::out_t     out;
	logic              idle;
	logic              frame_done;

	int            frame_pix [`MAP_WORDS];
	int            w_model [`CH_OUT][`CH_IN];
	cnn_pkg::out_t got_q [$];
	cnn_pkg::out_t saved_q [$];
	int            done_count;
	int            frame_first;
	int            errors;
	int            tests_run;
	logic [31:0]   lfsr_state;

	tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

	conv1x1_layer uut (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.pxl_in     (pxl_in),
		.wgt_we     (wgt_we),
		.wgt        (wgt),
		.out_valid  (out_valid),
		.out        (out),
		.idle       (idle),
		.frame_done (frame_done)
	);

	// Output monitor samples on the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (out_valid) begin
				got_q.push_back(out);
			end
			if (frame_done) begin
				done_count++;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired: the tests did not finish in time");
		$display("Test failures found");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Random numbers and reference model

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = (r << 1) | int'(lfsr_state[0]);
		end
		return r;
	endfunction

	function automatic int expected_pixel(input int oc, input int p);
		int sum;
		sum = 0;
		for (int ic = 0; ic < `CH_IN; ic++) begin
			sum += frame_pix[p * `CH_IN + ic] * w_model[oc][ic];
		end
		sum = sum >>> `REQ_SHIFT;
		if (sum < 0) begin
			sum = 0;
		end else if (sum > 255) begin
			sum = 255;
		end
		return sum;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus and checking

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_weights();
		for (int oc = 0; oc < `CH_OUT; oc++) begin
			for (int ic = 0; ic < `CH_IN; ic++) begin
				wgt_we      = 1'b1;
				wgt.out_ch  = `OUT_CH_W'(oc);
				wgt.in_ch   = `IN_CH_W'(ic);
				wgt.weight  = `WGT_W'(w_model[oc][ic]);
				next_cycle();
			end
		end
		wgt_we = 1'b0;
	endtask

	task automatic send_frame(input bit gapped);
		int gap;
		for (int w = 0; w < `MAP_WORDS; w++) begin
			valid_in = 1'b1;
			pxl_in   = `PIX_W'(frame_pix[w]);
			next_cycle();
			if (gapped) begin
				gap      = rand_bits(2);
				valid_in = 1'b0;
				repeat (gap) next_cycle();
			end
		end
		valid_in = 1'b0;
	endtask

	// Stray words while the stored map is being replayed
	task automatic pulse_during_replay(input int cycles);
		for (int k = 0; k < cycles; k++) begin
			valid_in = (k % 2 == 0);
			pxl_in   = `PIX_W'(rand_bits(8));
			next_cycle();
		end
		valid_in = 1'b0;
	endtask

	task automatic check_outputs(input int count);
		int n;
		int oc;
		int p;
		int exp;
		cnn_pkg::out_t got;
		assert (count == NUM_OUT) else begin
			$display("Fail at %0t ns: expected %0d outputs, got %0d", $time, NUM_OUT, count);
			errors++;
		end
		n = (count < NUM_OUT) ? count : NUM_OUT;
		for (int i = 0; i < n; i++) begin
			oc  = i / `NUM_PIX;
			p   = i % `NUM_PIX;
			exp = expected_pixel(oc, p);
			got = got_q[frame_first + i];
			assert (int'(got.out_ch) == oc && int'(got.pixel) == p) else begin
				$display("Fail at %0t ns: output %0d tagged oc %0d pixel %0d, expected %0d %0d",
					$time, i, got.out_ch, got.pixel, oc, p);
				errors++;
			end
			assert (int'(got.value) == exp) else begin
				$display("Fail at %0t ns: oc %0d pixel %0d value %0d, expected %0d",
					$time, oc, p, got.value, exp);
				errors++;
			end
		end
	endtask

	task automatic run_frame(input bit gapped, input bit replay_pulses);
		int done_start;
		int waited;
		frame_first = got_q.size();
		done_start  = done_count;
		waited      = 0;
		assert (idle) else begin
			$display("Fail at %0t ns: layer not idle before a new frame", $time);
			errors++;
		end
		send_frame(gapped);
		if (replay_pulses) begin
			pulse_during_replay((`CH_OUT - 1) * PASS_CYCLES - 16);
		end
		while (done_count == done_start && waited < FRAME_CYCLES) begin
			next_cycle();
			waited++;
		end
		assert (done_count != done_start) else begin
			$display("The frame never finished within %0d cycles", FRAME_CYCLES);
			errors++;
		end
		// Last result trails frame_done by one cycle
		repeat (4) next_cycle();
		assert (done_count - done_start == 1) else begin
			$display("Fail at %0t ns: %0d frame_done pulses, expected 1",
				$time, done_count - done_start);
			errors++;
		end
		check_outputs(got_q.size() - frame_first);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d failing checks", name, errors - errs_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		for (int k = 0; k < 20; k++) begin
			assert (idle && !out_valid && !frame_done) else begin
				$display("Fail at %0t ns: idle %0b out_valid %0b frame_done %0b after reset",
					$time, idle, out_valid, frame_done);
				errors++;
			end
			next_cycle();
		end
		report_test("reset_state", e0);
	endtask

	task automatic test_small_weights();
		int e0;
		e0 = errors;
		for (int w = 0; w < `MAP_WORDS; w++) begin
			frame_pix[w] = (w * 37 + 11) % 256;
		end
		for (int oc = 0; oc < `CH_OUT; oc++) begin
			for (int ic = 0; ic < `CH_IN; ic++) begin
				w_model[oc][ic] = (oc + ic) % 3 + 1;
			end
		end
		load_weights();
		run_frame(1'b0, 1'b0);
		report_test("small_weights", e0);
	endtask

	task automatic test_clip_limits();
		int e0;
		cnn_pkg::out_t got;
		e0 = errors;
		for (int w = 0; w < `MAP_WORDS; w++) begin
			frame_pix[w] = 200 + (w * 13) % 56;
		end
		for (int ic = 0; ic < `CH_IN; ic++) begin
			w_model[0][ic] = -100 - 5 * ic;
			w_model[1][ic] = 100 + 5 * ic;
			w_model[2][ic] = ic - 1;
		end
		load_weights();
		run_frame(1'b0, 1'b0);
		// Channel 0 must floor at 0, channel 1 must saturate
		for (int i = frame_first; i < got_q.size(); i++) begin
			got = got_q[i];
			assert (!(got.out_ch == 0 && got.value != 0)) else begin
				$display("Fail at %0t ns: negative sum gave %0d", $time, got.value);
				errors++;
			end
			assert (!(got.out_ch == 1 && got.value != 255)) else begin
				$display("Fail at %0t ns: large sum gave %0d", $time, got.value);
				errors++;
			end
		end
		report_test("clip_limits", e0);
	endtask

	task automatic test_random_gaps();
		int e0;
		int n;
		e0 = errors;
		for (int w = 0; w < `MAP_WORDS; w++) begin
			frame_pix[w] = rand_bits(8);
		end
		for (int oc = 0; oc < `CH_OUT; oc++) begin
			for (int ic = 0; ic < `CH_IN; ic++) begin
				w_model[oc][ic] = rand_bits(5) - 16;
			end
		end
		load_weights();
		run_frame(1'b1, 1'b0);
		saved_q.delete();
		for (int i = frame_first; i < got_q.size(); i++) begin
			saved_q.push_back(got_q[i]);
		end
		run_frame(1'b0, 1'b0);
		n = got_q.size() - frame_first;
		assert (n == saved_q.size()) else begin
			$display("Fail at %0t ns: gapped run gave %0d outputs, contiguous %0d",
				$time, saved_q.size(), n);
			errors++;
		end
		for (int i = 0; i < n && i < saved_q.size(); i++) begin
			assert (got_q[frame_first + i] == saved_q[i]) else begin
				$display("Fail at %0t ns: output %0d differs between gapped and contiguous",
					$time, i);
				errors++;
			end
		end
		report_test("random_gaps", e0);
	endtask

	task automatic test_new_weights();
		int e0;
		e0 = errors;
		// Fresh map and new weights for every channel
		for (int w = 0; w < `MAP_WORDS; w++) begin
			frame_pix[w] = (w * 23 + 61) % 256;
		end
		for (int oc = 0; oc < `CH_OUT; oc++) begin
			for (int ic = 0; ic < `CH_IN; ic++) begin
				w_model[oc][ic] = (ic % 2 == 0) ? (oc + 2) : -(oc + 1);
			end
		end
		assert (idle) else begin
			$display("Fail at %0t ns: layer not idle before the weight update", $time);
			errors++;
		end
		load_weights();
		run_frame(1'b0, 1'b0);
		report_test("new_weights", e0);
	endtask

	task automatic test_replay_pulses();
		int e0;
		e0 = errors;
		for (int w = 0; w < `MAP_WORDS; w++) begin
			frame_pix[w] = (w * 5 + 100) % 256;
		end
		for (int oc = 0; oc < `CH_OUT; oc++) begin
			for (int ic = 0; ic < `CH_IN; ic++) begin
				w_model[oc][ic] = 2;
			end
		end
		load_weights();
		run_frame(1'b0, 1'b1);
		report_test("replay_pulses", e0);
	endtask

	initial begin
		reset      = 1'b1;
		valid_in   = 1'b0;
		pxl_in     = '0;
		wgt_we     = 1'b0;
		wgt        = '0;
		lfsr_state = 32'he1ff;
		errors     = 0;
		tests_run  = 0;
		done_count = 0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		test_reset_state();
		test_small_weights();
		test_clip_limits();
		test_random_gaps();
		test_new_weights();
		test_replay_pulses();

		$display("Tests run: %0d, failing checks: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none
`timescale 1ns/1ns

// Free-running testbench clock
module tb_clock #(
	parameter int PERIOD_NS = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk = ~clk;
		end
	end

endmodule

`default_nettype wire
